/* source/id_remap_pkg.sv */
// ********************************************************************
// Shared widths, types and table sizes of the AXI ID remapper.
// The table size must stay a power of two matching IDX_W, and
// MST_ID_W must be at least IDX_W. CNT_W must hold MAX_TXNS_PER_ID.
// ********************************************************************
package id_remap_pkg;

  // Upstream IDs are wide and sparse, downstream IDs are dense.
  localparam int unsigned SLV_ID_W = 8;
  localparam int unsigned MST_ID_W = 3;

  // Number of distinct upstream IDs that may be in flight per direction.
  localparam int unsigned MAX_UNIQ_IDS = 4;
  // Number of transactions that one upstream ID may have in flight.
  localparam int unsigned MAX_TXNS_PER_ID = 3;

  localparam int unsigned IDX_W = 2;
  localparam int unsigned CNT_W = 2;

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 16;

  typedef logic [SLV_ID_W-1:0] slv_id_t;
  typedef logic [MST_ID_W-1:0] mst_id_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [CNT_W-1:0] cnt_t;
  // One bit per table entry.
  typedef logic [MAX_UNIQ_IDS-1:0] field_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [1:0] resp_t;

  // A request is either forwarded directly or held under back-pressure.
  typedef enum logic {IDLE = 1'b0, HOLD = 1'b1} remap_state_e;

endpackage

/* source/remap_table_if.sv */
// ********************************************************************
// Link between one direction controller and its remap table.
// The lookup results are combinational from the table registers.
// Pop signals are not part of this bundle.
// ********************************************************************
`timescale 1ns/1ps

interface remap_table_if;
  import id_remap_pkg::*;

  // Request side, driven by the controller.
  logic push;
  slv_id_t push_inp_id;
  idx_t push_oup_id;
  slv_id_t lookup_id;

  // Lookup results, driven by the table.
  logic exists;
  idx_t exists_oup_id;
  logic exists_full;
  idx_t free_oup_id;
  logic full;

  modport ctrl (
    output push, push_inp_id, push_oup_id, lookup_id,
    input exists, exists_oup_id, exists_full, free_oup_id, full
  );

  modport tbl (
    input push, push_inp_id, push_oup_id, lookup_id,
    output exists, exists_oup_id, exists_full, free_oup_id, full
  );
endinterface

/* source/remap_entry.sv */
// ********************************************************************
// One remap table entry: a held upstream ID and its in-flight count.
// The entry is free when the count is zero; the held ID is then stale.
// Push and pop in the same cycle leave the count unchanged.
// ********************************************************************
`timescale 1ns/1ps

module remap_entry (
  input logic clk_i,
  input logic rst_i,
  input logic push_i,
  input id_remap_pkg::slv_id_t push_id_i,
  input logic pop_i,
  input id_remap_pkg::slv_id_t lookup_id_i,
  output logic free_o,
  output logic match_o,
  output logic at_limit_o,
  output id_remap_pkg::slv_id_t inp_id_o
);
  import id_remap_pkg::*;

  cnt_t cnt_q;
  slv_id_t id_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10: cnt_q <= cnt_q + cnt_t'(1);
        2'b01: cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // A push only reaches a free entry or one that already holds this ID.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q <= push_id_i;
    end
  end

  assign free_o = (cnt_q == '0);
  // A stale ID in a free entry must never match.
  assign match_o = !free_o && (id_q == lookup_id_i);
  assign at_limit_o = (cnt_q == cnt_t'(MAX_TXNS_PER_ID));
  assign inp_id_o = id_q;

  // Responses from downstream only ever complete transactions in flight.
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !free_o);
  // The controller checks the limit through the table lookup.
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !at_limit_o);

endmodule

/* source/remap_table.sv */
// ********************************************************************
// Remap table for one direction, indexed by the downstream ID.
// Lookup and free search are combinational; push and pop act on the
// next clock edge. Response IDs must name an entry in flight.
// ********************************************************************
`timescale 1ns/1ps

module remap_table (
  input logic clk_i,
  input logic rst_i,
  remap_table_if.tbl tbl,
  input logic pop_i,
  input id_remap_pkg::idx_t pop_oup_id_i,
  output id_remap_pkg::slv_id_t pop_inp_id_o
);
  import id_remap_pkg::*;

  field_t free;
  field_t match;
  field_t at_limit;
  slv_id_t inp_ids [MAX_UNIQ_IDS];

  // Each entry gets its own push and pop strobe from the decoded index.
  for (genvar i = 0; i < MAX_UNIQ_IDS; i++) begin : gen_entry
    remap_entry i_entry (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .push_i (tbl.push && (tbl.push_oup_id == idx_t'(i))),
      .push_id_i (tbl.push_inp_id),
      .pop_i (pop_i && (pop_oup_id_i == idx_t'(i))),
      .lookup_id_i (tbl.lookup_id),
      .free_o (free[i]),
      .match_o (match[i]),
      .at_limit_o (at_limit[i]),
      .inp_id_o (inp_ids[i])
    );
  end

  // Priority encoders; the lowest set bit wins, so the loop runs downwards.
  always_comb begin
    tbl.free_oup_id = '0;
    tbl.exists_oup_id = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (free[i]) begin
        tbl.free_oup_id = idx_t'(i);
      end
      if (match[i]) begin
        tbl.exists_oup_id = idx_t'(i);
      end
    end
  end

  assign tbl.full = ~|free;
  assign tbl.exists = |match;
  assign tbl.exists_full = at_limit[tbl.exists_oup_id];

  // The response names the entry, which gives back the original ID.
  assign pop_inp_id_o = inp_ids[pop_oup_id_i];

  // One upstream ID is only ever held in a single entry.
  a_unique_match: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(match));

endmodule

/* source/remap_direction.sv */
// ********************************************************************
// Request controller for one address channel (AW or AR).
// Admissible requests pass in the same cycle with a remapped ID.
// The table is pushed once per request, on its first admissible cycle;
// under back-pressure the chosen ID is held until downstream accepts.
// ********************************************************************
`timescale 1ns/1ps

module remap_direction (
  input logic clk_i,
  input logic rst_i,
  input logic s_valid_i,
  output logic s_ready_o,
  input id_remap_pkg::slv_id_t s_id_i,
  output logic m_valid_o,
  input logic m_ready_i,
  output id_remap_pkg::mst_id_t m_id_o,
  remap_table_if.ctrl tbl
);
  import id_remap_pkg::*;

  remap_state_e state_q;
  remap_state_e state_d;
  idx_t hold_id_q;
  idx_t hold_id_d;
  idx_t chosen_id;
  idx_t oup_id;
  logic admissible;

  // The incoming ID is always looked up and is the one that gets pushed.
  assign tbl.lookup_id = s_id_i;
  assign tbl.push_inp_id = s_id_i;

  // An ID in flight keeps its output ID so that its ordering is preserved.
  assign chosen_id = tbl.exists ? tbl.exists_oup_id : tbl.free_oup_id;
  assign tbl.push_oup_id = chosen_id;

  // Either the ID is known and below its limit, or a new entry is free.
  assign admissible = (tbl.exists && !tbl.exists_full) || (!tbl.exists && !tbl.full);

  always_comb begin
    state_d = state_q;
    hold_id_d = hold_id_q;
    m_valid_o = 1'b0;
    s_ready_o = 1'b0;
    tbl.push = 1'b0;
    oup_id = chosen_id;
    case (state_q)
      IDLE: begin
        if (s_valid_i && admissible) begin
          m_valid_o = 1'b1;
          s_ready_o = m_ready_i;
          tbl.push = 1'b1;
          // Remember the ID, since the table view changes after the push.
          if (!m_ready_i) begin
            hold_id_d = chosen_id;
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        // The entry is already counted, so only the handshake is pending.
        m_valid_o = 1'b1;
        s_ready_o = m_ready_i;
        oup_id = hold_id_q;
        if (m_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // The table index sits in the low bits of the wider downstream ID.
  assign m_id_o = {{(MST_ID_W - IDX_W){1'b0}}, oup_id};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_id_q <= hold_id_d;
  end

  // A stalled downstream request keeps its valid and its ID.
  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_id_o));
  // A held request is already counted in the table under its own output ID.
  a_hold_counted: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q == HOLD |-> tbl.exists && (tbl.exists_oup_id == hold_id_q));

endmodule

/* source/id_remap_top.sv */
// ********************************************************************
// AXI ID remapper for the AW/B and AR/R channels, without W and ATOPs.
// Up to four upstream IDs per direction, three transactions each.
// Downstream must return IDs it was given; upper ID bits must be zero.
// Responses pass through combinationally with the upstream ID restored.
// ********************************************************************
`timescale 1ns/1ps

module id_remap_top (
  input logic clk_i,
  input logic rst_i,
  input logic s_aw_valid_i,
  output logic s_aw_ready_o,
  input id_remap_pkg::slv_id_t s_aw_id_i,
  input id_remap_pkg::addr_t s_aw_addr_i,
  output logic m_aw_valid_o,
  input logic m_aw_ready_i,
  output id_remap_pkg::mst_id_t m_aw_id_o,
  output id_remap_pkg::addr_t m_aw_addr_o,
  input logic m_b_valid_i,
  output logic m_b_ready_o,
  input id_remap_pkg::mst_id_t m_b_id_i,
  input id_remap_pkg::resp_t m_b_resp_i,
  output logic s_b_valid_o,
  input logic s_b_ready_i,
  output id_remap_pkg::slv_id_t s_b_id_o,
  output id_remap_pkg::resp_t s_b_resp_o,
  input logic s_ar_valid_i,
  output logic s_ar_ready_o,
  input id_remap_pkg::slv_id_t s_ar_id_i,
  input id_remap_pkg::addr_t s_ar_addr_i,
  output logic m_ar_valid_o,
  input logic m_ar_ready_i,
  output id_remap_pkg::mst_id_t m_ar_id_o,
  output id_remap_pkg::addr_t m_ar_addr_o,
  input logic m_r_valid_i,
  output logic m_r_ready_o,
  input id_remap_pkg::mst_id_t m_r_id_i,
  input id_remap_pkg::data_t m_r_data_i,
  input id_remap_pkg::resp_t m_r_resp_i,
  input logic m_r_last_i,
  output logic s_r_valid_o,
  input logic s_r_ready_i,
  output id_remap_pkg::slv_id_t s_r_id_o,
  output id_remap_pkg::data_t s_r_data_o,
  output id_remap_pkg::resp_t s_r_resp_o,
  output logic s_r_last_o
);
  import id_remap_pkg::*;

  logic wr_pop;
  logic rd_pop;

  remap_table_if wr_if ();
  remap_table_if rd_if ();

  // Address payloads are not touched by the remapping.
  assign m_aw_addr_o = s_aw_addr_i;
  assign m_ar_addr_o = s_ar_addr_i;

  // Response channels are plain wires except for the ID.
  assign s_b_valid_o = m_b_valid_i;
  assign m_b_ready_o = s_b_ready_i;
  assign s_b_resp_o = m_b_resp_i;
  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  assign s_r_data_o = m_r_data_i;
  assign s_r_resp_o = m_r_resp_i;
  assign s_r_last_o = m_r_last_i;

  // A write completes with its B beat, a read only with its last R beat.
  assign wr_pop = m_b_valid_i && s_b_ready_i;
  assign rd_pop = m_r_valid_i && s_r_ready_i && m_r_last_i;

  remap_direction i_aw_dir (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .s_valid_i (s_aw_valid_i),
    .s_ready_o (s_aw_ready_o),
    .s_id_i (s_aw_id_i),
    .m_valid_o (m_aw_valid_o),
    .m_ready_i (m_aw_ready_i),
    .m_id_o (m_aw_id_o),
    .tbl (wr_if)
  );

  remap_table i_wr_table (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tbl (wr_if),
    .pop_i (wr_pop),
    .pop_oup_id_i (m_b_id_i[IDX_W-1:0]),
    .pop_inp_id_o (s_b_id_o)
  );

  remap_direction i_ar_dir (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .s_valid_i (s_ar_valid_i),
    .s_ready_o (s_ar_ready_o),
    .s_id_i (s_ar_id_i),
    .m_valid_o (m_ar_valid_o),
    .m_ready_i (m_ar_ready_i),
    .m_id_o (m_ar_id_o),
    .tbl (rd_if)
  );

  remap_table i_rd_table (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tbl (rd_if),
    .pop_i (rd_pop),
    .pop_oup_id_i (m_r_id_i[IDX_W-1:0]),
    .pop_inp_id_o (s_r_id_o)
  );

  // Downstream only ever sees zero-extended IDs, so it must return them so.
  a_b_id_range: assert property (@(posedge clk_i) disable iff (rst_i)
    m_b_valid_i |-> (m_b_id_i[MST_ID_W-1:IDX_W] == '0));
  a_r_id_range: assert property (@(posedge clk_i) disable iff (rst_i)
    m_r_valid_i |-> (m_r_id_i[MST_ID_W-1:IDX_W] == '0));

endmodule

/* verification/remap_checker.sv */
// ********************************************************************
// Watches both directions of the remapper against a reference table.
// Index 0 of every bundled port is the write side, index 1 the read.
// Upstream addresses must stay stable while a request waits.
// Response payloads are expected to pass through unchanged.
// ********************************************************************
`timescale 1ns/1ps

module remap_checker (
  input logic clk_i,
  input logic rst_i,
  input logic [1:0] s_valid_i,
  input logic [1:0] s_ready_i,
  input id_remap_pkg::slv_id_t [1:0] s_id_i,
  input id_remap_pkg::addr_t [1:0] s_addr_i,
  input logic [1:0] m_valid_i,
  input logic [1:0] m_ready_i,
  input id_remap_pkg::mst_id_t [1:0] m_id_i,
  input id_remap_pkg::addr_t [1:0] m_addr_i,
  input logic [1:0] rsp_valid_i,
  input logic [1:0] rsp_ready_i,
  input logic [1:0] rsp_last_i,
  input id_remap_pkg::mst_id_t [1:0] rsp_m_id_i,
  input id_remap_pkg::slv_id_t [1:0] rsp_s_id_i,
  input logic [1:0] rsp_s_valid_i,
  input logic [1:0] rsp_m_ready_i,
  input id_remap_pkg::resp_t [1:0] rsp_m_resp_i,
  input id_remap_pkg::resp_t [1:0] rsp_s_resp_i,
  input id_remap_pkg::data_t r_m_data_i,
  input id_remap_pkg::data_t r_s_data_i,
  input logic r_s_last_i,
  output int err_cnt_o
);
  import id_remap_pkg::*;

  slv_id_t ref_id [2][MAX_UNIQ_IDS];
  int ref_cnt [2][MAX_UNIQ_IDS];
  logic [1:0] held;
  mst_id_t held_id [2];
  addr_t held_addr [2];
  int err_cnt = 0;

  assign err_cnt_o = err_cnt;

  // Reference rule: an ID in flight keeps its index, a new one takes the
  // lowest free index. The top bit says whether the request may pass.
  function automatic logic [IDX_W:0] expect_id(input int d, input slv_id_t id);
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      if (ref_cnt[d][i] != 0 && ref_id[d][i] == id) begin
        return {ref_cnt[d][i] < int'(MAX_TXNS_PER_ID), idx_t'(i)};
      end
    end
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      if (ref_cnt[d][i] == 0) begin
        return {1'b1, idx_t'(i)};
      end
    end
    return '0;
  endfunction

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  always @(posedge clk_i) begin
    logic [IDX_W:0] res;
    logic exp_valid;
    string ch;
    string rc;
    int idx;
    for (int d = 0; d < 2; d++) begin
      ch = (d == 1) ? "ar" : "aw";
      rc = (d == 1) ? "r" : "b";
      if (rst_i) begin
        held[d] = 1'b0;
        for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
          ref_cnt[d][i] = 0;
        end
        compare_value({"m_", ch, "_valid"}, 16'(m_valid_i[d]), 16'h0);
        compare_value({"s_", ch, "_ready"}, 16'(s_ready_i[d]), 16'h0);
      end else begin
        exp_valid = 1'b0;
        // A stalled request must be replayed unchanged, without a new push.
        if (held[d]) begin
          exp_valid = 1'b1;
          compare_value({"m_", ch, "_id"}, 16'(m_id_i[d]), 16'(held_id[d]));
          compare_value({"m_", ch, "_addr"}, 16'(m_addr_i[d]), 16'(held_addr[d]));
          held[d] = !m_ready_i[d];
        end else if (s_valid_i[d]) begin
          res = expect_id(d, s_id_i[d]);
          exp_valid = res[IDX_W];
          if (res[IDX_W]) begin
            idx = int'(res[IDX_W-1:0]);
            compare_value({"m_", ch, "_id"}, 16'(m_id_i[d]), 16'(res[IDX_W-1:0]));
            compare_value({"m_", ch, "_addr"}, 16'(m_addr_i[d]), 16'(s_addr_i[d]));
            ref_id[d][idx] = s_id_i[d];
            ref_cnt[d][idx]++;
            held[d] = !m_ready_i[d];
            held_id[d] = mst_id_t'(res[IDX_W-1:0]);
            held_addr[d] = s_addr_i[d];
          end
        end
        compare_value({"m_", ch, "_valid"}, 16'(m_valid_i[d]), 16'(exp_valid));
        compare_value({"s_", ch, "_ready"}, 16'(s_ready_i[d]),
                      16'(exp_valid & m_ready_i[d]));
        // Responses are checked against the table as it was before this edge.
        compare_value({"s_", rc, "_valid"}, 16'(rsp_s_valid_i[d]), 16'(rsp_valid_i[d]));
        compare_value({"m_", rc, "_ready"}, 16'(rsp_m_ready_i[d]), 16'(rsp_ready_i[d]));
        if (rsp_valid_i[d]) begin
          idx = int'(rsp_m_id_i[d][IDX_W-1:0]);
          compare_value({"s_", rc, "_id"}, 16'(rsp_s_id_i[d]), 16'(ref_id[d][idx]));
          compare_value({"s_", rc, "_resp"}, 16'(rsp_s_resp_i[d]), 16'(rsp_m_resp_i[d]));
          if (d == 1) begin
            compare_value("s_r_data", 16'(r_s_data_i), 16'(r_m_data_i));
            compare_value("s_r_last", 16'(r_s_last_i), 16'(rsp_last_i[1]));
          end
        end
        if (rsp_valid_i[d] && rsp_ready_i[d] && rsp_last_i[d]) begin
          idx = int'(rsp_m_id_i[d][IDX_W-1:0]);
          if (ref_cnt[d][idx] == 0) begin
            err_cnt++;
            $display("Response on %s for an output ID that is not in flight", ch);
          end else begin
            ref_cnt[d][idx]--;
          end
        end
      end
    end
  end

endmodule

/* verification/tb_id_remap.sv */
// ********************************************************************
// Testbench for the AXI ID remapper with random stalls and IDs.
// Six upstream IDs compete for four entries per direction, so both
// the table-full and the per-ID limit stalls occur.
// ********************************************************************
`timescale 1ns/1ps

module tb_id_remap;
  import id_remap_pkg::*;

  localparam int T_FILL = 60;
  localparam int T_MIX = 600;
  localparam int T_DRAIN = 200;
  localparam int LIMIT = (T_FILL + T_MIX + T_DRAIN) * 4;
  localparam slv_id_t POOL [6] = '{8'h13, 8'h5a, 8'ha7, 8'hc2, 8'h3f, 8'he9};

  logic clk_i = 1'b0;
  logic rst_i = 1'b1;
  logic s_aw_valid_i = 1'b0;
  logic m_aw_ready_i = 1'b0;
  logic m_b_valid_i = 1'b0;
  logic s_b_ready_i = 1'b0;
  logic s_ar_valid_i = 1'b0;
  logic m_ar_ready_i = 1'b0;
  logic m_r_valid_i = 1'b0;
  logic s_r_ready_i = 1'b0;
  logic m_r_last_i = 1'b0;
  slv_id_t s_aw_id_i = '0;
  slv_id_t s_ar_id_i = '0;
  addr_t s_aw_addr_i = '0;
  addr_t s_ar_addr_i = '0;
  mst_id_t m_b_id_i = '0;
  mst_id_t m_r_id_i = '0;
  resp_t m_b_resp_i = '0;
  resp_t m_r_resp_i = '0;
  data_t m_r_data_i = '0;
  logic s_aw_ready_o;
  logic m_aw_valid_o;
  logic m_b_ready_o;
  logic s_b_valid_o;
  logic s_ar_ready_o;
  logic m_ar_valid_o;
  logic m_r_ready_o;
  logic s_r_valid_o;
  logic s_r_last_o;
  mst_id_t m_aw_id_o;
  mst_id_t m_ar_id_o;
  slv_id_t s_b_id_o;
  slv_id_t s_r_id_o;
  addr_t m_aw_addr_o;
  addr_t m_ar_addr_o;
  resp_t s_b_resp_o;
  resp_t s_r_resp_o;
  data_t s_r_data_o;

  logic [15:0] lfsr_q = 16'd48;
  logic req_en = 1'b0;
  logic rsp_en = 1'b0;
  mst_id_t aw_q [$];
  mst_id_t ar_q [$];
  int cyc = 0;
  int err_cnt;
  int tb_err = 0;
  int n_fail = 0;

  id_remap_top id_remap_top_i (.*);

  remap_checker checker_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .s_valid_i ({s_ar_valid_i, s_aw_valid_i}),
    .s_ready_i ({s_ar_ready_o, s_aw_ready_o}),
    .s_id_i ({s_ar_id_i, s_aw_id_i}),
    .s_addr_i ({s_ar_addr_i, s_aw_addr_i}),
    .m_valid_i ({m_ar_valid_o, m_aw_valid_o}),
    .m_ready_i ({m_ar_ready_i, m_aw_ready_i}),
    .m_id_i ({m_ar_id_o, m_aw_id_o}),
    .m_addr_i ({m_ar_addr_o, m_aw_addr_o}),
    .rsp_valid_i ({m_r_valid_i, m_b_valid_i}),
    .rsp_ready_i ({s_r_ready_i, s_b_ready_i}),
    .rsp_last_i ({m_r_last_i, 1'b1}),
    .rsp_m_id_i ({m_r_id_i, m_b_id_i}),
    .rsp_s_id_i ({s_r_id_o, s_b_id_o}),
    .rsp_s_valid_i ({s_r_valid_o, s_b_valid_o}),
    .rsp_m_ready_i ({m_r_ready_o, m_b_ready_o}),
    .rsp_m_resp_i ({m_r_resp_i, m_b_resp_i}),
    .rsp_s_resp_i ({s_r_resp_o, s_b_resp_o}),
    .r_m_data_i (m_r_data_i),
    .r_s_data_i (s_r_data_o),
    .r_s_last_i (s_r_last_o),
    .err_cnt_o (err_cnt)
  );

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken.
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[14:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // All random draws happen here so that their order is fixed.
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (!s_aw_valid_i || s_aw_ready_o) begin
        s_aw_valid_i <= req_en && (take_bits(1) != 0);
        s_aw_id_i <= POOL[take_bits(3) % 6];
        s_aw_addr_i <= take_bits(16);
      end
      if (!s_ar_valid_i || s_ar_ready_o) begin
        s_ar_valid_i <= req_en && (take_bits(1) != 0);
        s_ar_id_i <= POOL[take_bits(3) % 6];
        s_ar_addr_i <= take_bits(16);
      end
      m_aw_ready_i <= take_bits(2) != 0;
      m_ar_ready_i <= take_bits(2) != 0;
      s_b_ready_i <= take_bits(2) != 0;
      s_r_ready_i <= take_bits(2) != 0;
      if (m_aw_valid_o && m_aw_ready_i) begin
        aw_q.push_back(m_aw_id_o);
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        ar_q.push_back(m_ar_id_o);
      end
      // Downstream responder for B.
      if (m_b_valid_i && m_b_ready_o) begin
        m_b_valid_i <= 1'b0;
      end else if (!m_b_valid_i && rsp_en && aw_q.size() > 0 && take_bits(1) != 0) begin
        m_b_valid_i <= 1'b1;
        m_b_id_i <= aw_q.pop_front();
        m_b_resp_i <= resp_t'(take_bits(2));
      end
      // Downstream responder for R with bursts of one or two beats.
      if (m_r_valid_i && m_r_ready_o) begin
        m_r_valid_i <= !m_r_last_i;
        m_r_last_i <= 1'b1;
        m_r_data_i <= take_bits(16);
      end else if (!m_r_valid_i && rsp_en && ar_q.size() > 0 && take_bits(1) != 0) begin
        m_r_valid_i <= 1'b1;
        m_r_id_i <= ar_q.pop_front();
        m_r_last_i <= take_bits(1) != 0;
        m_r_data_i <= take_bits(16);
        m_r_resp_i <= resp_t'(take_bits(2));
      end
    end
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("Timeout: the run exceeded %0d cycles", LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic run_test(input int num, input string name, input logic req,
                          input logic rsp, input int len, input logic drain);
    int errs_before;
    int bad;
    errs_before = err_cnt + tb_err;
    req_en <= req;
    rsp_en <= rsp;
    repeat (len) @(posedge clk_i);
    // The checker counts on the rising edge, so the counts settle by the falling one.
    @(negedge clk_i);
    // At the end of the drain every accepted request must have completed.
    if (drain && (aw_q.size() != 0 || ar_q.size() != 0 || m_b_valid_i || m_r_valid_i)) begin
      tb_err++;
      $display("Responses still outstanding after the drain phase");
    end
    bad = err_cnt + tb_err - errs_before;
    if (bad != 0) begin
      n_fail++;
    end
    $display("test %0d (%s): %s, %0d errors", num, name, (bad == 0) ? "ok" : "failed", bad);
  endtask

  initial begin
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    run_test(1, "fill without responses", 1'b1, 1'b0, T_FILL, 1'b0);
    run_test(2, "random traffic", 1'b1, 1'b1, T_MIX, 1'b0);
    run_test(3, "drain", 1'b0, 1'b1, T_DRAIN, 1'b1);
    $display("3 tests run, %0d failed, %0d errors", n_fail, err_cnt + tb_err);
    if (err_cnt + tb_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* id_remap.f */
source/id_remap_pkg.sv
source/remap_table_if.sv
source/remap_entry.sv
source/remap_table.sv
source/remap_direction.sv
source/id_remap_top.sv
verification/remap_checker.sv
verification/tb_id_remap.sv

/* Makefile */
# Verilator flow for the AXI ID remapper.
VERILATOR ?= verilator
TOP       ?= tb_id_remap
FILELIST  ?= id_remap.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_id_remap
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
